// File: files.f
+incdir+test
verilog/starforce_pkg.sv
verilog/pixel_timing.sv
verilog/plane_shifter.sv
verilog/tile_layer.sv
verilog/sprite_layer.sv
verilog/layer_mixer.sv
verilog/starforce_video.sv
test/tb_starforce_video.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the video path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_starforce_video \
   -f files.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "^Done: no errors$"; then
   exit 0
else
   exit 1
fi

// File: test/video_model.svh
// reference model: tile and sprite copies, pixel code selection and layer priority
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

localparam int TILES = (1 << HPOS_W) / TILE_W;

// planes and banks as sampled at each tile boundary, by tile number
plane_t fg_copy      [TILES][3];
bank_t  fg_copy_bank [TILES];
plane_t bg_copy      [TILES][3];
bank_t  bg_copy_bank [TILES];

// sprite copy and the absolute pixel count of its trigger
plane_t spr_copy [3];
bank_t  spr_copy_bank;
int     spr_start;

task automatic clear_model();
   for (int t = 0; t < TILES; t++)
   begin
      for (int p = 0; p < 3; p++)
      begin
         fg_copy[t][p] = '0;
         bg_copy[t][p] = '0;
      end
      fg_copy_bank[t] = '0;
      bg_copy_bank[t] = '0;
   end
   for (int p = 0; p < 3; p++)
      spr_copy[p] = '0;
   spr_copy_bank = '0;
   // far enough back that no pixel sees a sprite
   spr_start = -(2 * TILE_W);
endtask

task automatic store_tile(input int tile, input plane_t f0, input plane_t f1,
                          input plane_t f2, input bank_t fb, input plane_t b0,
                          input plane_t b1, input plane_t b2, input bank_t bb);
   fg_copy[tile][0]   = f0;
   fg_copy[tile][1]   = f1;
   fg_copy[tile][2]   = f2;
   fg_copy_bank[tile] = fb;
   bg_copy[tile][0]   = b0;
   bg_copy[tile][1]   = b1;
   bg_copy[tile][2]   = b2;
   bg_copy_bank[tile] = bb;
endtask

task automatic start_sprite(input int pix, input plane_t s0, input plane_t s1,
                            input plane_t s2, input bank_t sb);
   spr_copy[0]   = s0;
   spr_copy[1]   = s1;
   spr_copy[2]   = s2;
   spr_copy_bank = sb;
   spr_start     = pix;
endtask

// plane 2 gives the msb of the code
function automatic code_t plane_code(input plane_t p0, input plane_t p1, input plane_t p2,
                                     input int bit_idx);
   return {p2[bit_idx], p1[bit_idx], p0[bit_idx]};
endfunction

function automatic color_t expected_color(input int pix);
   int     tile;
   int     bit_idx;
   int     run;
   code_t  fg_c;
   code_t  bg_c;
   code_t  spr_c;
   color_t c;
   tile    = (pix / TILE_W) % TILES;
   bit_idx = TILE_W - 1 - (pix % TILE_W);
   fg_c = plane_code(fg_copy[tile][0], fg_copy[tile][1], fg_copy[tile][2], bit_idx);
   bg_c = plane_code(bg_copy[tile][0], bg_copy[tile][1], bg_copy[tile][2], bit_idx);
   // bits 7 down to 0 on the eight pixels after the trigger
   run = pix - spr_start;
   if (run >= 1 && run <= TILE_W)
      spr_c = plane_code(spr_copy[0], spr_copy[1], spr_copy[2], TILE_W - run);
   else
      spr_c = '0;
   if (spr_c != 3'd0)
   begin
      c.layer = LAYER_SPRITE;
      c.bank  = spr_copy_bank;
      c.code  = spr_c;
   end
   else if (fg_c != 3'd0)
   begin
      c.layer = LAYER_FG;
      c.bank  = fg_copy_bank[tile];
      c.code  = fg_c;
   end
   else if (bg_c != 3'd0)
   begin
      c.layer = LAYER_BG;
      c.bank  = bg_copy_bank[tile];
      c.code  = bg_c;
   end
   else
   begin
      c.layer = LAYER_BACKDROP;
      c.bank  = '0;
      c.code  = '0;
   end
   return c;
endfunction

`endif

// File: test/tb_starforce_video.sv
// testbench for the video path: clock, reset, random stimulus, model checks and summary
`timescale 1ns/1ns

module tb_starforce_video
   import starforce_pkg::*;
();

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 5;
   // pixels per test
   localparam int PIX_T1 = 32;
   localparam int PIX_T2 = 256;
   localparam int PIX_T3 = 256;
   localparam int PIX_T4 = 512;
   localparam int PIX_T5 = 1024;
   localparam int MARGIN_PIX  = 32;
   localparam int CYCLE_LIMIT = RESET_CYCLES +
      (PIX_T1 + PIX_T2 + PIX_T3 + PIX_T4 + PIX_T5 + MARGIN_PIX) * PIX_DIV;

   logic   clk;
   logic   CR;
   plane_t fg_plane0;
   plane_t fg_plane1;
   plane_t fg_plane2;
   bank_t  fg_bank;
   plane_t bg_plane0;
   plane_t bg_plane1;
   plane_t bg_plane2;
   bank_t  bg_bank;
   hpos_t  sprite_x;
   plane_t spr_plane0;
   plane_t spr_plane1;
   plane_t spr_plane2;
   bank_t  spr_bank;
   logic   pix_ce_o;
   color_t color_o;
   hpos_t  pixel_x_o;

   // stimulus modes, switched on test by test
   bit     fg_on;
   bit     bg_on;
   bit     spr_on;
   bit     spr_far;

   int     pix_cnt;
   int     cycle_cnt;
   int     last_ce;
   int     spr_pix;
   int     errors;
   int     checks;
   int     tests_run;
   bit     tile_due;
   color_t exp_color;

   `include "video_model.svh"

   starforce_video dut_i (
      .clk          (clk),
      .CR           (CR),
      .fg_plane0_i  (fg_plane0),
      .fg_plane1_i  (fg_plane1),
      .fg_plane2_i  (fg_plane2),
      .fg_bank_i    (fg_bank),
      .bg_plane0_i  (bg_plane0),
      .bg_plane1_i  (bg_plane1),
      .bg_plane2_i  (bg_plane2),
      .bg_bank_i    (bg_bank),
      .sprite_x_i   (sprite_x),
      .spr_plane0_i (spr_plane0),
      .spr_plane1_i (spr_plane1),
      .spr_plane2_i (spr_plane2),
      .spr_bank_i   (spr_bank),
      .pix_ce_o     (pix_ce_o),
      .color_o      (color_o),
      .pixel_x_o    (pixel_x_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ==================================================
   // checks and stimulus
   // ==================================================

   task automatic check_value(input string what, input int got, input int exp);
      checks++;
      if (got != exp)
      begin
         errors++;
         $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // new tile data right after a tile boundary
   task automatic drive_tile_inputs();
      // sparse foreground so the background shows through
      fg_plane0 = fg_on ? plane_t'($urandom & $urandom) : '0;
      fg_plane1 = fg_on ? plane_t'($urandom & $urandom) : '0;
      fg_plane2 = fg_on ? plane_t'($urandom & $urandom) : '0;
      fg_bank   = fg_on ? bank_t'($urandom) : '0;
      bg_plane0 = bg_on ? plane_t'($urandom) : '0;
      bg_plane1 = bg_on ? plane_t'($urandom) : '0;
      bg_plane2 = bg_on ? plane_t'($urandom) : '0;
      bg_bank   = bg_on ? bank_t'($urandom) : '0;
      if (!spr_on)
      begin
         spr_plane0 = '0;
         spr_plane1 = '0;
         spr_plane2 = '0;
         spr_bank   = '0;
      end
      else if ((pix_cnt / TILE_W) % 4 == 0)
      begin
         // near start lands within the next 24 pixels
         if (spr_far)
            sprite_x = hpos_t'($urandom);
         else
            sprite_x = hpos_t'(pix_cnt + int'($urandom % 24));
         spr_plane0 = plane_t'($urandom);
         spr_plane1 = plane_t'($urandom);
         spr_plane2 = plane_t'($urandom);
         spr_bank   = bank_t'($urandom);
      end
   endtask

   // on a strobe, the mixer output holds the previous pixel
   task automatic sample_pixel();
      int tile;
      if (pix_ce_o)
      begin
         if (pix_cnt == 0)
         begin
            check_value("colour after reset", int'(color_o), 0);
            check_value("pixel_x after reset", int'(pixel_x_o), 0);
         end
         else
         begin
            check_value($sformatf("strobe spacing before pixel %0d", pix_cnt),
                        cycle_cnt - last_ce, PIX_DIV);
            check_value($sformatf("pixel_x after pixel %0d", pix_cnt - 1),
                        int'(pixel_x_o), int'(hpos_t'(pix_cnt - 1)));
            check_value($sformatf("colour of pixel %0d", pix_cnt - 1),
                        int'(color_o), int'(exp_color));
         end
         exp_color = expected_color(pix_cnt);
         if (exp_color.layer == LAYER_SPRITE)
            spr_pix++;
         if (hpos_t'(pix_cnt) == sprite_x)
            start_sprite(pix_cnt, spr_plane0, spr_plane1, spr_plane2, spr_bank);
         // tile boundary, planes are sampled on this strobe
         if (pix_cnt % TILE_W == TILE_W - 1)
         begin
            tile = ((pix_cnt + 1) / TILE_W) % TILES;
            store_tile(tile, fg_plane0, fg_plane1, fg_plane2, fg_bank,
                       bg_plane0, bg_plane1, bg_plane2, bg_bank);
            tile_due = 1'b1;
         end
         last_ce = cycle_cnt;
         pix_cnt++;
      end
   endtask

   task automatic run_test(input int num, input string name, input int pixels);
      int first_err;
      int end_pix;
      first_err = errors;
      end_pix   = pix_cnt + pixels;
      spr_pix   = 0;
      while (pix_cnt < end_pix)
      begin
         @(posedge clk);
         #1;
         if (tile_due)
         begin
            drive_tile_inputs();
            tile_due = 1'b0;
         end
         sample_pixel();
      end
      tests_run++;
      $display("test %0d %s: %0d pixels, %0d sprite pixels, %0d errors",
               num, name, pixels, spr_pix, errors - first_err);
   endtask

   // ==================================================
   // main sequence
   // ==================================================

   initial
   begin
      void'($urandom(32'h6978));
      CR         = 1'b0;
      fg_plane0  = '0;
      fg_plane1  = '0;
      fg_plane2  = '0;
      fg_bank    = '0;
      bg_plane0  = '0;
      bg_plane1  = '0;
      bg_plane2  = '0;
      bg_bank    = '0;
      sprite_x   = '0;
      spr_plane0 = '0;
      spr_plane1 = '0;
      spr_plane2 = '0;
      spr_bank   = '0;
      fg_on      = 1'b0;
      bg_on      = 1'b0;
      spr_on     = 1'b0;
      spr_far    = 1'b0;
      pix_cnt    = 0;
      last_ce    = 0;
      spr_pix    = 0;
      errors     = 0;
      checks     = 0;
      tests_run  = 0;
      tile_due   = 1'b0;
      exp_color  = '0;
      clear_model();

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      CR = 1'b1;

      run_test(1, "reset and pixel timing", PIX_T1);
      bg_on = 1'b1;
      run_test(2, "background only", PIX_T2);
      fg_on = 1'b1;
      run_test(3, "foreground over background", PIX_T3);
      spr_on = 1'b1;
      run_test(4, "sprite over tiles", PIX_T4);
      spr_far = 1'b1;
      run_test(5, "long random run", PIX_T5);

      $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   // run limit from the total pixel count
   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycle_cnt = cycle_cnt + 1;
      end
      $display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
   end

endmodule

// File: verilog/layer_mixer.sv
// layer priority selection and registered colour index with pixel position
`timescale 1ns/1ns

module layer_mixer
   import starforce_pkg::*;
(
   input  logic   clk,
   input  logic   CR,
   input  logic   pix_ce_i,
   input  hpos_t  hpos_i,
   input  code_t  spr_code_i,
   input  code_t  fg_code_i,
   input  code_t  bg_code_i,
   input  bank_t  spr_bank_i,
   input  bank_t  fg_bank_i,
   input  bank_t  bg_bank_i,
   output color_t color_o,
   output hpos_t  pixel_x_o
);

   logic [2:0] opaque;
   layer_t     sel;
   color_t     color_d;

   assign opaque = {|bg_code_i, |fg_code_i, |spr_code_i};

   // priority encoder, frontmost opaque layer wins
   always_comb
   begin
      if (opaque[0])
         sel = LAYER_SPRITE;
      else if (opaque[1])
         sel = LAYER_FG;
      else if (opaque[2])
         sel = LAYER_BG;
      else
         sel = LAYER_BACKDROP;
   end

   // 4-to-1 selector for bank and code
   always_comb
   begin
      color_d.layer = sel;
      case (sel)
         LAYER_SPRITE:
         begin
            color_d.bank = spr_bank_i;
            color_d.code = spr_code_i;
         end
         LAYER_FG:
         begin
            color_d.bank = fg_bank_i;
            color_d.code = fg_code_i;
         end
         LAYER_BG:
         begin
            color_d.bank = bg_bank_i;
            color_d.code = bg_code_i;
         end
         default:
         begin
            // backdrop has a zero bank and code
            color_d.bank = '0;
            color_d.code = '0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         color_o   <= '0;
         pixel_x_o <= '0;
      end
      else if (pix_ce_i)
      begin
         color_o   <= color_d;
         pixel_x_o <= hpos_i;
      end
   end

   // backdrop only when every layer was transparent for that pixel
   a_backdrop : assert property (@(posedge clk) disable iff (!CR)
      pix_ce_i |=> ((color_o.layer == LAYER_BACKDROP) ==
                    ($past(spr_code_i) == '0 && $past(fg_code_i) == '0 &&
                     $past(bg_code_i) == '0)));

endmodule

// File: verilog/pixel_timing.sv
// pixel strobe divider, horizontal pixel counter and tile boundary strobe
`timescale 1ns/1ns

module pixel_timing
   import starforce_pkg::*;
(
   input  logic  clk,
   input  logic  CR,
   output logic  pix_ce_o,
   output hpos_t hpos_o,
   output logic  tile_load_o
);

   logic [DIV_W-1:0] div_cnt;
   hpos_t            hpos_q;

   // modulo PIX_DIV divider, strobe on the last count
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         div_cnt <= '0;
      else if (div_cnt == DIV_W'(PIX_DIV - 1))
         div_cnt <= '0;
      else
         div_cnt <= div_cnt + 1'b1;
   end

   assign pix_ce_o = (div_cnt == DIV_W'(PIX_DIV - 1));

   // horizontal counter, wraps at 256
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         hpos_q <= '0;
      else if (pix_ce_o)
         hpos_q <= hpos_q + 1'b1;
   end

   assign hpos_o = hpos_q;

   // last pixel of a tile, so the next tile loads as hpos steps over
   assign tile_load_o = pix_ce_o && (&hpos_q[TILE_SH-1:0]);

   // pixel strobes are evenly spaced
   a_pix_ce_period : assert property (@(posedge clk) disable iff (!CR)
      pix_ce_o |=> !pix_ce_o [*PIX_DIV-1] ##1 pix_ce_o);

endmodule

// File: verilog/plane_shifter.sv
// load, shift and hold register for one bit plane, msb out first
`timescale 1ns/1ns

module plane_shifter
   import starforce_pkg::*;
#(
   parameter type T = plane_t
)
(
   input  logic clk,
   input  logic CR,
   input  logic load_i,
   input  logic shift_i,
   input  T     par_i,
   output logic msb_o
);

   logic [$bits(T)-1:0] q;

   // modes as in a universal shift register
   // load wins, shift fills zeros from the lsb side
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         q <= '0;
      end
      else
      begin
         case ({load_i, shift_i})
            2'b10,
            2'b11:   q <= par_i;
            2'b01:   q <= {q[$bits(T)-2:0], 1'b0};
            default: q <= q;
         endcase
      end
   end

   // pixel bit is always the top of the register
   assign msb_o = q[$bits(T)-1];

   // callers must never load and shift on the same strobe
   a_no_load_shift : assert property (@(posedge clk) disable iff (!CR)
      !(load_i && shift_i));

endmodule

// File: verilog/sprite_layer.sv
// sprite layer: position comparator, sprite plane shifters and run counter
`timescale 1ns/1ns

module sprite_layer
   import starforce_pkg::*;
(
   input  logic   clk,
   input  logic   CR,
   input  logic   pix_ce_i,
   input  hpos_t  hpos_i,
   input  hpos_t  sprite_x_i,
   input  plane_t splane0_i,
   input  plane_t splane1_i,
   input  plane_t splane2_i,
   input  bank_t  sbank_i,
   output code_t  code_o,
   output bank_t  bank_o
);

   logic             hit;
   logic             shift;
   logic [RUN_W-1:0] run_cnt;
   logic             bit0;
   logic             bit1;
   logic             bit2;
   bank_t            bank_q;

   // ==================================================
   // trigger and run control
   // ==================================================

   // start on the pixel at sprite_x, first bit shows one pixel later
   assign hit = pix_ce_i && (hpos_i == sprite_x_i);

   // eight shifts empty the registers, zero fill keeps them transparent
   assign shift = pix_ce_i && !hit && (run_cnt != '0);

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         run_cnt <= '0;
      else if (hit)
         run_cnt <= RUN_W'(TILE_W);
      else if (shift)
         run_cnt <= run_cnt - 1'b1;
   end

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         bank_q <= '0;
      else if (hit)
         bank_q <= sbank_i;
   end

   // ==================================================
   // sprite planes
   // ==================================================

   plane_shifter #(.T(plane_t)) splane0_sh (
      .clk     (clk),
      .CR      (CR),
      .load_i  (hit),
      .shift_i (shift),
      .par_i   (splane0_i),
      .msb_o   (bit0)
   );

   plane_shifter #(.T(plane_t)) splane1_sh (
      .clk     (clk),
      .CR      (CR),
      .load_i  (hit),
      .shift_i (shift),
      .par_i   (splane1_i),
      .msb_o   (bit1)
   );

   plane_shifter #(.T(plane_t)) splane2_sh (
      .clk     (clk),
      .CR      (CR),
      .load_i  (hit),
      .shift_i (shift),
      .par_i   (splane2_i),
      .msb_o   (bit2)
   );

   assign code_o = {bit2, bit1, bit0};
   assign bank_o = bank_q;

endmodule

// File: verilog/starforce_pkg.sv
// raster constants, pixel payload types and layer codes for the video path
package starforce_pkg;

   // ==================================================
   // raster constants
   // ==================================================

   // 48 MHz system clock divided down to the 6 MHz pixel rate
   localparam int PIX_DIV = 8;
   localparam int DIV_W   = $clog2(PIX_DIV);

   // 256 pixels per line, wraps without a blanking region
   localparam int HPOS_W  = 8;

   // tiles and the sprite are both one byte wide
   localparam int TILE_W  = 8;
   localparam int TILE_SH = $clog2(TILE_W);
   // sprite run counter has to hold the full width
   localparam int RUN_W   = $clog2(TILE_W + 1);

   // ==================================================
   // pixel payloads
   // ==================================================

   typedef logic [HPOS_W-1:0] hpos_t;
   typedef logic [TILE_W-1:0] plane_t;
   typedef logic [3:0]        bank_t;

   // plane 2 is the msb, zero is transparent
   typedef logic [2:0]        code_t;

   // order also gives the priority, sprite in front
   typedef enum logic [1:0] {
      LAYER_SPRITE   = 2'd0,
      LAYER_FG       = 2'd1,
      LAYER_BG       = 2'd2,
      LAYER_BACKDROP = 2'd3
   } layer_t;

   // 9-bit colour index into the palette
   typedef struct packed {
      layer_t layer;
      bank_t  bank;
      code_t  code;
   } color_t;

endpackage

// File: verilog/starforce_video.sv
// video path top level: raster timing, two tile layers, sprite layer and mixer
`timescale 1ns/1ns

module starforce_video
   import starforce_pkg::*;
(
   input  logic   clk,
   input  logic   CR,
   input  plane_t fg_plane0_i,
   input  plane_t fg_plane1_i,
   input  plane_t fg_plane2_i,
   input  bank_t  fg_bank_i,
   input  plane_t bg_plane0_i,
   input  plane_t bg_plane1_i,
   input  plane_t bg_plane2_i,
   input  bank_t  bg_bank_i,
   input  hpos_t  sprite_x_i,
   input  plane_t spr_plane0_i,
   input  plane_t spr_plane1_i,
   input  plane_t spr_plane2_i,
   input  bank_t  spr_bank_i,
   output logic   pix_ce_o,
   output color_t color_o,
   output hpos_t  pixel_x_o
);

   logic  pix_ce;
   logic  tile_load;
   hpos_t hpos;
   code_t fg_code;
   code_t bg_code;
   code_t spr_code;
   bank_t fg_bank;
   bank_t bg_bank;
   bank_t spr_bank;

   // ==================================================
   // raster timing
   // ==================================================

   pixel_timing timing_i (
      .clk         (clk),
      .CR          (CR),
      .pix_ce_o    (pix_ce),
      .hpos_o      (hpos),
      .tile_load_o (tile_load)
   );

   assign pix_ce_o = pix_ce;

   // ==================================================
   // layers
   // ==================================================

   tile_layer fg_layer (
      .clk         (clk),
      .CR          (CR),
      .pix_ce_i    (pix_ce),
      .tile_load_i (tile_load),
      .plane0_i    (fg_plane0_i),
      .plane1_i    (fg_plane1_i),
      .plane2_i    (fg_plane2_i),
      .bank_i      (fg_bank_i),
      .code_o      (fg_code),
      .bank_o      (fg_bank)
   );

   tile_layer bg_layer (
      .clk         (clk),
      .CR          (CR),
      .pix_ce_i    (pix_ce),
      .tile_load_i (tile_load),
      .plane0_i    (bg_plane0_i),
      .plane1_i    (bg_plane1_i),
      .plane2_i    (bg_plane2_i),
      .bank_i      (bg_bank_i),
      .code_o      (bg_code),
      .bank_o      (bg_bank)
   );

   sprite_layer spr_layer (
      .clk        (clk),
      .CR         (CR),
      .pix_ce_i   (pix_ce),
      .hpos_i     (hpos),
      .sprite_x_i (sprite_x_i),
      .splane0_i  (spr_plane0_i),
      .splane1_i  (spr_plane1_i),
      .splane2_i  (spr_plane2_i),
      .sbank_i    (spr_bank_i),
      .code_o     (spr_code),
      .bank_o     (spr_bank)
   );

   // ==================================================
   // priority mix
   // ==================================================

   layer_mixer mixer_i (
      .clk        (clk),
      .CR         (CR),
      .pix_ce_i   (pix_ce),
      .hpos_i     (hpos),
      .spr_code_i (spr_code),
      .fg_code_i  (fg_code),
      .bg_code_i  (bg_code),
      .spr_bank_i (spr_bank),
      .fg_bank_i  (fg_bank),
      .bg_bank_i  (bg_bank),
      .color_o    (color_o),
      .pixel_x_o  (pixel_x_o)
   );

endmodule

// File: verilog/tile_layer.sv
// tile layer: three plane shifters and the palette bank latch
`timescale 1ns/1ns

module tile_layer
   import starforce_pkg::*;
(
   input  logic   clk,
   input  logic   CR,
   input  logic   pix_ce_i,
   input  logic   tile_load_i,
   input  plane_t plane0_i,
   input  plane_t plane1_i,
   input  plane_t plane2_i,
   input  bank_t  bank_i,
   output code_t  code_o,
   output bank_t  bank_o
);

   logic  shift;
   logic  bit0;
   logic  bit1;
   logic  bit2;
   bank_t bank_q;

   // shift on every pixel strobe except the tile boundary
   assign shift = pix_ce_i && !tile_load_i;

   plane_shifter #(.T(plane_t)) plane0_sh (
      .clk     (clk),
      .CR      (CR),
      .load_i  (tile_load_i),
      .shift_i (shift),
      .par_i   (plane0_i),
      .msb_o   (bit0)
   );

   plane_shifter #(.T(plane_t)) plane1_sh (
      .clk     (clk),
      .CR      (CR),
      .load_i  (tile_load_i),
      .shift_i (shift),
      .par_i   (plane1_i),
      .msb_o   (bit1)
   );

   plane_shifter #(.T(plane_t)) plane2_sh (
      .clk     (clk),
      .CR      (CR),
      .load_i  (tile_load_i),
      .shift_i (shift),
      .par_i   (plane2_i),
      .msb_o   (bit2)
   );

   // bank comes with the planes of the same tile
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         bank_q <= '0;
      else if (tile_load_i)
         bank_q <= bank_i;
   end

   assign code_o = {bit2, bit1, bit0};
   assign bank_o = bank_q;

endmodule
